// ==== Bender.yml ====
package:
  name: obj_draw

sources:
  # packages first, the stages refer to them by scope
  - source/obj_draw_pkg.sv
  - source/tile_rom_pkg.sv
  # drawing stages
  - source/sprite_cmd_latch.sv
  - source/tile_row_fetch.sv
  - source/pixel_emitter.sv
  - source/obj_line_buffer.sv
  # top level
  - source/obj_draw.sv
  # testbench
  - target: simulation
    files:
      - bench/obj_draw_tb.sv

// ==== bench/obj_draw_tb.sv ====
// testbench for obj_draw that reads the tests file, draws sprites, models the ROM and checks pxl
`timescale 1ns/1ps

module obj_draw_tb;

    localparam logic [3:0] alpha_pen = 4'd0;
    localparam int first_chk = 3;   // earlier lines read banks that were never cleared
    localparam int last_chk  = 8;

    logic                    clk;
    logic                    rst;
    logic                    draw;
    obj_draw_pkg::draw_cmd_t cmd;
    logic                    busy;
    tile_rom_pkg::rom_addr_t rom_addr;
    logic                    rom_cs;
    logic                    rom_ok;
    tile_rom_pkg::rom_word_u rom_data;
    logic                    pxl_cen;
    logic                    hs;
    obj_draw_pkg::buf_addr_t hdump;
    obj_draw_pkg::buf_addr_t next_h;
    logic                    flip;
    obj_draw_pkg::pixel_t    pxl;

    logic [63:0]             recs [64];                // raw records from the tests file
    logic [31:0]             rom_mem [2**17];
    obj_draw_pkg::pixel_t    exp_pix [16][512];        // expected readout per line and hdump
    logic                    flip_at [16];
    obj_draw_pkg::draw_cmd_t cmd_q [$];
    int                      cmd_line [$];
    tile_rom_pkg::rom_addr_t exp_addr [$];             // ROM requests the bench expects next
    int                      errors = 0;
    int                      pix_checks = 0;
    int                      line_no = 0;              // bumps on each rising edge of hs
    int                      rom_done = 0;             // completed ROM transactions
    int                      chk_line;
    obj_draw_pkg::buf_addr_t chk_h;
    logic                    chk_pend = 1'b0;

    obj_draw #(
        .packed_rom (1'b0),
        .alpha_pen  (alpha_pen),
        .keep_old   (1'b0),
        .flip_offset(0)
    ) i_obj_draw (
        .clk, .rst, .draw, .cmd, .busy,
        .rom_addr, .rom_cs, .rom_ok, .rom_data,
        .pxl_cen, .hs, .hdump, .flip, .pxl
    );

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("errors: %0d, pixels checked: %0d", errors, pix_checks);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic stall(input string what);
        errors++;
        $display("timeout: %s", what);
        end_run();
    endtask

    task automatic load_tests();
        logic [63:0]             r;
        obj_draw_pkg::buf_addr_t h;
        obj_draw_pkg::pixel_t    v;
        obj_draw_pkg::draw_cmd_t c;
        bit                      stop;
        stop = 0;
        for (int a = 0; a < 2**17; a++) begin
            rom_mem[a] = 32'hc3a50000 ^ (a * 32'h9e37);  // unloaded words are easy to spot
        end
        for (int l = 0; l < 16; l++) begin
            flip_at[l] = 1'b0;
            for (int a = 0; a < 512; a++) begin
                exp_pix[l][a] = obj_draw_pkg::pixel_t'(alpha_pen);
            end
        end
        $readmemh("bench/obj_draw_tests.txt", recs);
        for (int i = 0; i < 64 && !stop; i++) begin
            r = recs[i];
            if ($isunknown(r) || r[63:60] == 4'hf) begin
                stop = 1;
            end else begin
                case (r[63:60])
                    4'h1: rom_mem[{r[51:40], r[36], r[35:32]}] = r[31:0];
                    4'h2: begin
                        c       = '0;
                        c.code  = r[51:40];
                        c.xpos  = r[36:28];
                        c.ysub  = r[27:24];
                        c.hflip = r[21];
                        c.vflip = r[20];
                        c.pal   = r[19:16];
                        cmd_q.push_back(c);
                        cmd_line.push_back(int'(r[59:52]));
                    end
                    4'h3: begin
                        h = r[48:40];
                        v = r[39:32];
                        for (int k = 0; k < r[31:24]; k++) begin
                            exp_pix[r[59:52]][h] = v;
                            h = h + 1'b1;          // runs may wrap past the line end
                            v = v + r[23:16];      // ff steps down
                        end
                    end
                    4'h4: flip_at[r[59:52]] = r[48];
                    default: begin
                        errors++;
                        $display("unknown record kind in tests file at entry %0d", i);
                    end
                endcase
            end
        end
        if (cmd_q.size() == 0) begin
            errors++;
            $display("no commands were read from the tests file");
        end
    endtask

    // wait on negedge so the line count is never read while it changes
    task automatic wait_line(input int ln);
        int t;
        t = 0;
        while (line_no < ln) begin
            @(negedge clk);
            t++;
            if (t > 2200) stall($sformatf("line %0d never started", ln));
        end
    endtask

    task automatic send_cmd(input obj_draw_pkg::draw_cmd_t c);
        int                      t;
        int                      base;
        tile_rom_pkg::rom_addr_t a;
        t = 0;
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
            t++;
            if (t > 200) stall("busy never dropped before the next command");
        end
        a.code = c.code;
        a.row  = c.vflip ? 4'd15 - c.ysub : c.ysub;
        a.half = 1'b0;
        exp_addr.push_back(a);                     // left half first
        a.half = 1'b1;
        exp_addr.push_back(a);
        base = rom_done;
        draw <= 1'b1;
        cmd  <= c;
        @(posedge clk);                            // accepted here
        draw <= 1'b0;
        @(posedge clk);
        compare("busy", busy, 1);
        t = 0;
        while (busy) begin
            @(posedge clk);
            t++;
            if (t > 200) stall("fetch never handed the row to the emitter");
        end
        compare("rom words before hand-off", rom_done - base, 2);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // video timing with pxl_cen every other clk and hs over hdump 480..511
    initial begin
        forever begin
            @(posedge clk);
            if (pxl_cen) begin
                chk_h    = hdump;
                chk_line = line_no;
                chk_pend = 1'b1;
            end
            if (!pxl_cen) begin
                pxl_cen <= 1'b1;
            end else begin
                next_h = hdump + 1'b1;
                pxl_cen <= 1'b0;
                hdump   <= next_h;
                hs      <= next_h >= 9'd480;
                if (next_h == 9'd480) begin
                    line_no++;
                    flip <= flip_at[line_no % 16];  // flip changes only with the line
                end
            end
        end
    end

    // pxl is stable half a clk after the edge that loaded it
    initial begin
        forever begin
            @(negedge clk);
            if (chk_pend) begin
                chk_pend = 1'b0;
                if (chk_line >= first_chk && chk_line <= last_chk) begin
                    compare($sformatf("pxl line %0d hdump %0d", chk_line, chk_h),
                            pxl, exp_pix[chk_line][chk_h]);
                    pix_checks++;
                end
            end
        end
    end

    // ROM model with 0..3 cycles of random delay per word
    initial begin
        int lag;
        bit req_open;
        lag      = $urandom(65018);
        req_open = 0;
        forever begin
            @(posedge clk);
            if (rom_ok) begin
                rom_ok <= 1'b0;                    // word was taken on this edge
            end else if (rom_cs && !rst) begin
                if (!req_open) begin
                    req_open = 1;
                    lag      = $urandom % 4;
                    if (exp_addr.size() == 0) begin
                        errors++;
                        $display("ROM request seen with no command pending");
                    end else begin
                        compare("rom_addr", rom_addr, exp_addr.pop_front());
                    end
                end
                if (lag == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_mem[rom_addr];
                    req_open = 0;
                    rom_done++;
                end else begin
                    lag--;
                end
            end
        end
    end

    initial begin
        int n;
        rst      = 1'b1;
        draw     = 1'b0;
        cmd      = '0;
        rom_ok   = 1'b0;
        rom_data = '0;
        pxl_cen  = 1'b0;
        hs       = 1'b0;
        hdump    = '0;
        flip     = 1'b0;
        load_tests();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int ln = 1; ln <= last_chk - 1; ln++) begin
            wait_line(ln);
            n = cmd_q.size();
            for (int k = 0; k < n; k++) begin
                if (cmd_line[k] == ln) send_cmd(cmd_q[k]);  // back to back within a line
            end
        end
        wait_line(last_chk + 1);
        @(posedge clk);                            // last pixel of the final line is checked
        end_run();
    end

endmodule

// ==== bench/obj_draw_tests.txt ====
// records of 16 hex digits, first digit is the kind: 1 rom, 2 command, 3 expected run, 4 flip, f end
// 1_00_code_half_row_word | 2_line_code_xpos_ysub_flags(h=2,v=1)_pal | 3_line_hdump_value_count_step
// rom: code 001 row 0 gives pens 1..15 then the alpha pen
1_00_001_0_0_011e66aa
1_00_001_1_0_fe1e66aa
// rom: code 001 row 15 gives pen 1 on the left half, pen 2 on the right half
1_00_001_0_f_000000ff
1_00_001_1_f_0000ff00
// rom: code 002 row 3 is transparent on the left, pen 4 on the right
1_00_002_0_3_00000000
1_00_002_1_3_00ff0000
// commands, drawn on the given line and shown on the next one
2_02_001_010_0_0_3_0000
2_03_001_100_0_2_5_0000
2_03_001_040_0_1_2_0000
2_04_001_080_0_0_1_0000
2_04_002_080_3_0_7_0000
2_06_001_020_0_0_6_0000
2_07_001_1f8_0_0_4_0000
// screen flip during readout of line 7
4_07_1_000000000000
// expected runs, every other pixel of lines 3 to 8 is the alpha pen
3_03_010_31_0f_01_0000
3_04_101_5f_0f_ff_0000
3_04_040_21_08_00_0000
3_04_048_22_08_00_0000
3_05_080_11_08_01_0000
3_05_088_74_08_00_0000
3_07_1d1_6f_0f_ff_0000
3_08_1f8_41_08_01_0000
3_08_000_49_07_01_0000
f_000000000000000

// ==== obj_draw.f ====
source/obj_draw_pkg.sv
source/tile_rom_pkg.sv
source/sprite_cmd_latch.sv
source/tile_row_fetch.sv
source/pixel_emitter.sv
source/obj_line_buffer.sv
source/obj_draw.sv
bench/obj_draw_tb.sv

// ==== source/obj_draw.sv ====
// sprite line drawer top: command latch, ROM row fetch, pixel emitter and double line buffer
`timescale 1ns/1ps

module obj_draw #(
    parameter bit         packed_rom  = 1'b0,  // ROM word layout, 0 = planar
    parameter logic [3:0] alpha_pen   = 4'd0,  // transparent pen
    parameter bit         keep_old    = 1'b0,  // reverse priority
    parameter int         flip_offset = 0      // readout shift under screen flip
) (
    input  logic                    clk,
    input  logic                    rst,
    // draw commands
    input  logic                    draw,
    input  obj_draw_pkg::draw_cmd_t cmd,
    output logic                    busy,
    // graphics ROM
    output tile_rom_pkg::rom_addr_t rom_addr,
    output logic                    rom_cs,
    input  logic                    rom_ok,
    input  tile_rom_pkg::rom_word_u rom_data,
    // video timing
    input  logic                    pxl_cen,
    input  logic                    hs,
    input  obj_draw_pkg::buf_addr_t hdump,
    input  logic                    flip,
    // pixel out, one per pxl_cen
    output obj_draw_pkg::pixel_t    pxl
);

    logic                    start;
    logic                    hand_off;
    obj_draw_pkg::draw_cmd_t held;
    tile_rom_pkg::tile_row_t row;
    logic                    row_valid;
    logic                    emit_ready;
    logic                    buf_we;
    obj_draw_pkg::buf_addr_t buf_addr;
    obj_draw_pkg::pixel_t    buf_data;

    sprite_cmd_latch i_latch (
        .clk, .rst, .draw, .cmd, .hand_off,
        .busy, .start, .held
    );

    tile_row_fetch #(.packed_rom(packed_rom)) i_fetch (
        .clk, .rst, .start, .held, .rom_ok, .rom_data, .emit_ready,
        .hand_off, .rom_addr, .rom_cs, .row, .row_valid
    );

    // done marks the last pixel of a row, the emitter uses it for its own ready
    pixel_emitter #(.alpha_pen(alpha_pen)) i_emit (
        .clk, .rst, .row, .row_valid,
        .emit_ready, .buf_we, .buf_addr, .buf_data, .done()
    );

    obj_line_buffer #(
        .alpha_pen  (alpha_pen),
        .keep_old   (keep_old),
        .flip_offset(flip_offset)
    ) i_buf (
        .clk, .rst, .pxl_cen, .hs, .flip, .hdump,
        .buf_we, .buf_addr, .buf_data, .pxl
    );

endmodule

// ==== source/obj_draw_pkg.sv ====
// shared widths and the draw command word, referenced by scope from every drawing stage
package obj_draw_pkg;

    // buffer and command widths
    localparam int aw = 9;   // line buffer address width, 512 pixels per line
    localparam int cw = 12;  // sprite code width
    localparam int pw = 8;   // pixel width, palette on top of the 4-bit pen

    // one line buffer address, also used for hdump
    typedef logic [aw-1:0] buf_addr_t;

    // one pixel as stored in the line buffer
    typedef logic [pw-1:0] pixel_t;

    // one sprite row request, as presented on the draw port
    typedef struct packed {
        logic [cw-1:0] code;   // tile number in graphics ROM
        logic [aw-1:0] xpos;   // leftmost buffer column
        logic [3:0]    ysub;   // row inside the 16x16 tile
        logic          hflip;  // mirror left/right
        logic          vflip;  // mirror top/bottom
        logic [pw-5:0] pal;    // palette, ends up in the upper pixel bits
    } draw_cmd_t;

    // field layout from the msb down
    //   code  [30:19]
    //   xpos  [18:10]
    //   ysub  [9:6]
    //   hflip [5]
    //   vflip [4]
    //   pal   [3:0]
    // total 31 bits

endpackage

// ==== source/obj_line_buffer.sv ====
// double line buffer: one bank is drawn while the other plays back and clears the previous line
`timescale 1ns/1ps

module obj_line_buffer #(
    parameter logic [3:0] alpha_pen   = 4'd0,  // transparent pen, also the cleared value
    parameter bit         keep_old    = 1'b0,  // 1 keeps the pixel that got there first
    parameter int         flip_offset = 0      // screen flip alignment
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    hs,
    input  logic                    flip,
    input  obj_draw_pkg::buf_addr_t hdump,
    input  logic                    buf_we,
    input  obj_draw_pkg::buf_addr_t buf_addr,
    input  obj_draw_pkg::pixel_t    buf_data,
    output obj_draw_pkg::pixel_t    pxl
);

    localparam int depth = 2 ** (obj_draw_pkg::aw + 1);  // two banks back to back
    localparam obj_draw_pkg::pixel_t blank = obj_draw_pkg::pixel_t'(alpha_pen);

    obj_draw_pkg::pixel_t      mem [depth];
    logic                      line;     // bank being drawn
    logic                      hs_l;
    obj_draw_pkg::buf_addr_t   hdfix;    // readout count
    obj_draw_pkg::buf_addr_t   rd_addr;
    logic [obj_draw_pkg::aw:0] wr_ptr;
    logic [obj_draw_pkg::aw:0] rd_ptr;
    logic                      wr_ok;

    // banks swap at the start of each hsync
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs_l <= 1'b0;
            line <= 1'b0;
        end else begin
            hs_l <= hs;
            if (hs && !hs_l) begin
                line <= ~line;
            end
        end
    end

    // hdump may wrap a little before blanking, which would read back the
    // start of the line at its right edge. the count only resyncs to hdump
    // when hdump runs ahead or during hs, otherwise it just keeps going
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdfix <= '0;
        end else if (pxl_cen) begin
            hdfix <= (hdump > hdfix || hs) ? hdump + 1'b1 : hdfix + 1'b1;
        end
    end

    always_comb begin
        rd_addr = hdfix;
        if (flip) begin
            rd_addr = ~hdfix + obj_draw_pkg::buf_addr_t'(flip_offset);  // mirrored readout
        end
    end

    assign wr_ptr = {line, buf_addr};
    assign rd_ptr = {~line, rd_addr};   // never the bank under drawing

    // reverse priority: only a location still at the alpha pen takes a write
    assign wr_ok = !keep_old || mem[wr_ptr][3:0] == alpha_pen;

    // pixel storage
    always_ff @(posedge clk) begin
        if (buf_we && wr_ok) begin
            mem[wr_ptr] <= buf_data;
        end
        if (pxl_cen) begin
            mem[rd_ptr] <= blank;       // clear behind the read for the next use
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= mem[rd_ptr];         // one clk of read latency
        end
    end

    // each location read out is left blank for the next time this bank is drawn
    a_clear_after_read : assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> mem[$past(rd_ptr)] == blank)
        else $error("line buffer location not cleared after readout");

endmodule

// ==== source/pixel_emitter.sv ====
// pixel emitter: walks the 16 pens of a row in flip order and issues line buffer writes
`timescale 1ns/1ps

module pixel_emitter #(
    parameter logic [3:0] alpha_pen = 4'd0  // transparent pen, never written
) (
    input  logic                    clk,
    input  logic                    rst,
    input  tile_rom_pkg::tile_row_t row,
    input  logic                    row_valid,
    output logic                    emit_ready,
    output logic                    buf_we,
    output obj_draw_pkg::buf_addr_t buf_addr,
    output obj_draw_pkg::pixel_t    buf_data,
    output logic                    done
);

    tile_rom_pkg::tile_row_t cur;     // row being drawn
    logic                    active;
    logic [3:0]              cnt;     // pixel position from xpos
    logic [3:0]              sel;     // pen index after hflip
    logic [3:0]              pen;
    logic                    take;

    // last pixel of the row goes out this cycle
    assign done       = active && cnt == 4'd15;

    // ready on the last pixel too, so rows run back to back
    assign emit_ready = !active || done;
    assign take       = row_valid && emit_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= 4'd0;
        end else if (take) begin
            active <= 1'b1;
            cnt    <= 4'd0;
        end else if (active) begin
            cnt <= cnt + 4'd1;    // wraps to 0 after the last pixel
            if (done) begin
                active <= 1'b0;
            end
        end
    end

    // row payload
    always_ff @(posedge clk) begin
        if (take) begin
            cur <= row;
        end
    end

    assign sel = cnt ^ {4{cur.hflip}};  // 15 - cnt when mirrored
    assign pen = cur.pens[sel];

    // blank pens still use their cycle, they just don't write
    assign buf_we = active && pen != alpha_pen;

    assign buf_addr = cur.xpos + obj_draw_pkg::buf_addr_t'(cnt);  // wraps at the line end
    assign buf_data = {cur.pal, pen};

    // a row once taken always finishes 16 cycles later, no stalls on this side
    a_row_length : assert property (@(posedge clk) disable iff (rst)
        take |-> ##16 done)
        else $error("row did not complete in 16 cycles");

endmodule

// ==== source/sprite_cmd_latch.sv ====
// command latch that takes one draw command while idle and holds it until the fetch hands off
`timescale 1ns/1ps

module sprite_cmd_latch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    draw,      // command strobe from the sprite scanner
    input  obj_draw_pkg::draw_cmd_t cmd,
    input  logic                    hand_off,  // row passed on to the emitter
    output logic                    busy,
    output logic                    start,     // one-cycle kick for the fetch
    output obj_draw_pkg::draw_cmd_t held
);

    logic accept;

    assign accept = draw && !busy;  // commands seen while busy are simply ignored

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;        // start lines up with the first cycle of busy
            if (accept) begin
                busy <= 1'b1;
            end else if (hand_off) begin
                busy <= 1'b0;       // fetch is free again, next command may come
            end
        end
    end

    // command fields, loaded on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= cmd;
        end
    end

    // the fetch may only hand off a row that started from a command held here
    a_hand_off_busy : assert property (@(posedge clk) disable iff (rst)
        hand_off |-> busy)
        else $error("hand-off seen while no command was held");

endmodule

// ==== source/tile_rom_pkg.sv ====
// graphics ROM address, the two views of a ROM word and the unpacked row handed to the emitter
package tile_rom_pkg;

    // {code, half, row}, same order as the ROM is laid out
    typedef struct packed {
        logic [obj_draw_pkg::cw-1:0] code;
        logic                        half;  // 0 = left 8 pixels, 1 = right 8 pixels
        logic [3:0]                  row;   // tile row after vflip
    } rom_addr_t;

    // one 32-bit ROM word, decoded one of two ways depending on the board layout
    typedef union packed {
        logic [3:0][7:0] planes;   // {plane3, plane2, plane1, plane0}, bit 7 is the left pixel
        logic [7:0][3:0] nibbles;  // one pen per nibble, top nibble is the left pixel
    } rom_word_u;

    // a fully fetched sprite row
    typedef struct packed {
        logic [15:0][3:0]                pens;  // pens[0] is the leftmost pixel before hflip
        logic [obj_draw_pkg::pw-5:0]     pal;   // carried over from the command
        logic [obj_draw_pkg::aw-1:0]     xpos;
        logic                            hflip;
    } tile_row_t;

endpackage

// ==== source/tile_row_fetch.sv ====
// row fetch stage: reads both ROM words of one sprite row and unpacks them into 16 pens
`timescale 1ns/1ps

module tile_row_fetch #(
    parameter bit packed_rom = 1'b0  // 1 selects the nibble layout
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  obj_draw_pkg::draw_cmd_t held,
    input  logic                    rom_ok,
    input  tile_rom_pkg::rom_word_u rom_data,
    input  logic                    emit_ready,
    output logic                    hand_off,
    output tile_rom_pkg::rom_addr_t rom_addr,
    output logic                    rom_cs,
    output tile_rom_pkg::tile_row_t row,
    output logic                    row_valid
);

    typedef enum logic [1:0] {
        st_idle,   // waiting for start
        st_left,   // half 0 requested
        st_right,  // half 1 requested
        st_wait    // row complete, waiting for the emitter
    } state_t;

    state_t                  state;
    tile_rom_pkg::tile_row_t row_r;
    logic [3:0]              vrow;

    // eight pens out of one ROM word, index 0 is the leftmost pixel
    function automatic logic [7:0][3:0] unpack(input tile_rom_pkg::rom_word_u w);
        logic [7:0][3:0] p;
        for (int j = 0; j < 8; j++) begin
            if (packed_rom) begin
                p[j] = w.nibbles[7-j];
            end else begin
                // one bit from each plane, plane 3 is the pen msb
                p[j] = {w.planes[3][7-j], w.planes[2][7-j], w.planes[1][7-j], w.planes[0][7-j]};
            end
        end
        return p;
    endfunction

    assign vrow      = held.vflip ? ~held.ysub : held.ysub;  // 15 - ysub when flipped
    assign hand_off  = row_valid && emit_ready;               // emitter takes the row now
    assign row       = row_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            rom_cs    <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: if (start) begin
                    rom_cs <= 1'b1;
                    state  <= st_left;
                end
                st_left: if (rom_ok) state <= st_right;  // cs stays up for the second word
                st_right: if (rom_ok) begin
                    rom_cs    <= 1'b0;
                    row_valid <= 1'b1;
                    state     <= st_wait;
                end
                default: if (emit_ready) begin  // st_wait, held until the emitter frees up
                    row_valid <= 1'b0;
                    state     <= st_idle;
                end
            endcase
        end
    end

    // address and row payload
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            rom_addr.code <= held.code;
            rom_addr.half <= 1'b0;       // left half first
            rom_addr.row  <= vrow;
            row_r.pal     <= held.pal;
            row_r.xpos    <= held.xpos;
            row_r.hflip   <= held.hflip;
        end
        if (state == st_left && rom_ok) begin
            rom_addr.half   <= 1'b1;
            row_r.pens[7:0] <= unpack(rom_data);
        end
        if (state == st_right && rom_ok) begin
            row_r.pens[15:8] <= unpack(rom_data);
        end
    end

    // ROM side expects a steady request until it answers
    a_rom_req_stable : assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom_addr moved while a ROM request was pending");

endmodule
